/* hdl/idct_dual_port_ram.sv */
`timescale 1ns/1ps

module idct_dual_port_ram #(
	parameter int WIDTH = 16
) (
	input logic Clock,
	input logic wr_en,
	input logic [idct_pkg::ADDR_WIDTH-1:0] wr_addr,
	input logic [WIDTH-1:0] wr_data,
	input idct_pkg::ram_rd_t rd,
	output logic [WIDTH-1:0] rd_data
);

	logic [WIDTH-1:0] mem [idct_pkg::BLOCK_SIZE];

	always_ff @(posedge Clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read, data one cycle after the address
	always_ff @(posedge Clock) begin
		rd_data <= mem[rd.addr];
	end

	// Read and write addresses come from different blocks and must never meet
	assert property (@(posedge Clock) !(wr_en && (wr_addr == rd.addr)))
		else $error("RAM read and write of address %0d in the same cycle", wr_addr);

endmodule

/* hdl/idct_mac.sv */
`timescale 1ns/1ps

module idct_mac (
	input logic Clock,
	input logic Resetn,
	input idct_pkg::mac_ctl_t mac_ctl,
	input logic signed [idct_pkg::COEF_WIDTH-1:0] coef_data,
	input logic signed [idct_pkg::T_WIDTH-1:0] t_data,
	output logic t_wr_en,
	output logic [idct_pkg::ADDR_WIDTH-1:0] t_wr_addr,
	output logic signed [idct_pkg::T_WIDTH-1:0] t_wr_data,
	output idct_pkg::pixel_t pixel
);

	logic row_pass;
	logic [2:0] cos_col;
	logic signed [idct_pkg::COEF_WIDTH-1:0] cos_val;
	logic signed [idct_pkg::ACC_WIDTH-1:0] operand;
	logic signed [idct_pkg::ACC_WIDTH-1:0] product;
	logic signed [idct_pkg::ACC_WIDTH-1:0] acc;
	logic signed [idct_pkg::ACC_WIDTH-1:0] acc_sum;
	logic signed [idct_pkg::ACC_WIDTH-1:0] row_scaled;
	logic signed [idct_pkg::ACC_WIDTH-1:0] col_scaled;
	logic [7:0] pixel_clip;
	logic pix_valid;
	logic [idct_pkg::ADDR_WIDTH-1:0] pix_index;
	logic [7:0] pix_value;

	assign row_pass = (mac_ctl.pass == idct_pkg::PASS_ROW);

	// Row pass walks n by column, column pass walks it by row
	assign cos_col = row_pass ? mac_ctl.out_index[2:0] : mac_ctl.out_index[5:3];
	assign cos_val = idct_pkg::DCT_MATRIX[mac_ctl.k][cos_col];

	assign operand = row_pass ?
		{{(idct_pkg::ACC_WIDTH-idct_pkg::COEF_WIDTH){coef_data[idct_pkg::COEF_WIDTH-1]}},
			coef_data} :
		{{(idct_pkg::ACC_WIDTH-idct_pkg::T_WIDTH){t_data[idct_pkg::T_WIDTH-1]}}, t_data};

	assign product = operand * cos_val;
	assign acc_sum = (mac_ctl.first ? '0 : acc) + product; // Restart on first
	assign row_scaled = acc_sum >>> idct_pkg::ROW_SHIFT;
	assign col_scaled = acc_sum >>> idct_pkg::COL_SHIFT;

	always_comb begin
		if (acc_sum[idct_pkg::ACC_WIDTH-1]) begin
			pixel_clip = 8'd0;
		end else if (|acc_sum[idct_pkg::ACC_WIDTH-2:idct_pkg::T_WIDTH]) begin
			pixel_clip = idct_pkg::PIXEL_MAX; // Overflow past bit 23
		end else begin
			pixel_clip = col_scaled[7:0];
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			t_wr_en <= 1'b0;
			pix_valid <= 1'b0;
		end else begin
			t_wr_en <= mac_ctl.valid && mac_ctl.last && row_pass;
			pix_valid <= mac_ctl.valid && mac_ctl.last && !row_pass;
		end
	end

	always_ff @(posedge Clock) begin
		if (mac_ctl.valid) begin
			acc <= acc_sum;
		end
		if (mac_ctl.valid && mac_ctl.last) begin
			t_wr_addr <= mac_ctl.out_index;
			t_wr_data <= row_scaled[idct_pkg::T_WIDTH-1:0];
			pix_index <= mac_ctl.out_index;
			pix_value <= pixel_clip;
		end
	end

	assign pixel = '{valid: pix_valid, index: pix_index, value: pix_value};

	assert property (@(posedge Clock) disable iff (!Resetn) !(t_wr_en && pixel.valid))
		else $error("T write and pixel strobe in the same cycle");

endmodule

/* hdl/idct_pkg.sv */
package idct_pkg;

	localparam int BLOCK_DIM = 8;
	localparam int BLOCK_SIZE = 64;
	localparam int ADDR_WIDTH = 6;
	localparam int COEF_WIDTH = 16;
	localparam int T_WIDTH = 24;
	localparam int ACC_WIDTH = 32;
	localparam int ROW_SHIFT = 8;
	localparam int COL_SHIFT = 16;
	localparam logic [7:0] PIXEL_MAX = 8'd255;

	// c(k)*cos((2n+1)k*pi/16) in Q12, indexed [k][n]
	localparam logic signed [COEF_WIDTH-1:0] DCT_MATRIX [BLOCK_DIM][BLOCK_DIM] = '{
		'{16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448,
			16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448},
		'{16'sd2009, 16'sd1703, 16'sd1138, 16'sd400,
			-16'sd400, -16'sd1138, -16'sd1703, -16'sd2009},
		'{16'sd1892, 16'sd784, -16'sd784, -16'sd1892,
			-16'sd1892, -16'sd784, 16'sd784, 16'sd1892},
		'{16'sd1703, -16'sd400, -16'sd2009, -16'sd1138,
			16'sd1138, 16'sd2009, 16'sd400, -16'sd1703},
		'{16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448,
			16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448},
		'{16'sd1138, -16'sd2009, 16'sd400, 16'sd1703,
			-16'sd1703, -16'sd400, 16'sd2009, -16'sd1138},
		'{16'sd784, -16'sd1892, 16'sd1892, -16'sd784,
			-16'sd784, 16'sd1892, -16'sd1892, 16'sd784},
		'{16'sd400, -16'sd1138, 16'sd1703, -16'sd2009,
			16'sd2009, -16'sd1703, 16'sd1138, -16'sd400}
	};

	typedef enum logic [1:0] {
		PASS_IDLE,
		PASS_ROW,
		PASS_DRAIN,
		PASS_COL
	} pass_e;

	// Host write port into the coefficient store
	typedef struct packed {
		logic we;
		logic [ADDR_WIDTH-1:0] addr;
		logic signed [COEF_WIDTH-1:0] data;
	} coef_wr_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
	} ram_rd_t;

	// One multiply-accumulate step
	typedef struct packed {
		logic valid;
		pass_e pass;
		logic first;
		logic last;
		logic [2:0] k;
		logic [ADDR_WIDTH-1:0] out_index;
	} mac_ctl_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_WIDTH-1:0] index;
		logic [7:0] value;
	} pixel_t;

endpackage

/* hdl/idct_sequencer.sv */
`timescale 1ns/1ps

module idct_sequencer (
	input logic Clock,
	input logic Resetn,
	input logic start,
	input idct_pkg::coef_wr_t coef_wr,
	output logic coef_wr_en,
	output logic [idct_pkg::ADDR_WIDTH-1:0] coef_wr_addr,
	output idct_pkg::ram_rd_t coef_rd,
	output idct_pkg::ram_rd_t t_rd,
	output idct_pkg::mac_ctl_t mac_ctl,
	output logic busy,
	output logic done
);

	idct_pkg::pass_e state;
	logic [idct_pkg::ADDR_WIDTH-1:0] out_idx;
	logic [2:0] k;
	logic [1:0] drain_cnt;
	logic issue;
	logic step_end;
	logic block_end;
	idct_pkg::mac_ctl_t mac_ctl_d;

	// Column pass stops issuing once its tail count starts
	assign issue = (state == idct_pkg::PASS_ROW) ||
		((state == idct_pkg::PASS_COL) && (drain_cnt == 2'd0));
	assign step_end = &k;
	assign block_end = step_end && (&out_idx);

	assign busy = (state != idct_pkg::PASS_IDLE);

	// Host writes only land while idle
	assign coef_wr_en = coef_wr.we && (state == idct_pkg::PASS_IDLE);
	assign coef_wr_addr = coef_wr.addr;

	// Idle read parks away from the host write address
	assign coef_rd.addr = (state == idct_pkg::PASS_IDLE) ? ~coef_wr.addr : {out_idx[5:3], k};

	// During the row pass this stays one index ahead of the T write
	assign t_rd.addr = (state == idct_pkg::PASS_ROW) ? out_idx : {k, out_idx[2:0]};

	always_comb begin
		mac_ctl_d.valid = issue;
		mac_ctl_d.pass = state;
		mac_ctl_d.first = (k == 3'd0);
		mac_ctl_d.last = step_end;
		mac_ctl_d.k = k;
		mac_ctl_d.out_index = out_idx;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= idct_pkg::PASS_IDLE;
			out_idx <= '0;
			k <= 3'd0;
			drain_cnt <= 2'd0;
			done <= 1'b0;
			mac_ctl <= '0;
		end else begin
			mac_ctl <= mac_ctl_d; // Lines up with RAM read data
			done <= 1'b0;

			if (issue) begin
				k <= k + 3'd1;
				if (step_end) begin
					out_idx <= out_idx + 1'b1;
				end
			end

			case (state)
				idct_pkg::PASS_IDLE: begin
					if (start) begin
						state <= idct_pkg::PASS_ROW;
					end
				end
				idct_pkg::PASS_ROW: begin
					if (block_end) begin
						state <= idct_pkg::PASS_DRAIN;
					end
				end
				idct_pkg::PASS_DRAIN: begin
					// Two cycles so the last T write lands first
					drain_cnt <= drain_cnt + 2'd1;
					if (drain_cnt == 2'd1) begin
						drain_cnt <= 2'd0;
						state <= idct_pkg::PASS_COL;
					end
				end
				idct_pkg::PASS_COL: begin
					if ((drain_cnt != 2'd0) || block_end) begin
						drain_cnt <= drain_cnt + 2'd1;
					end
					if (drain_cnt == 2'd2) begin // Last pixel is out
						drain_cnt <= 2'd0;
						state <= idct_pkg::PASS_IDLE;
						done <= 1'b1;
					end
				end
				default: state <= idct_pkg::PASS_IDLE;
			endcase
		end
	end

	assert property (@(posedge Clock) disable iff (!Resetn)
		done |-> ($past(state) == idct_pkg::PASS_COL) && (state == idct_pkg::PASS_IDLE))
		else $error("done raised outside the end of the column pass");

	// Back to back steps count k up, and a restart only follows a last step
	assert property (@(posedge Clock) disable iff (!Resetn)
		(mac_ctl.valid && $past(mac_ctl.valid)) |->
			(mac_ctl.first ? $past(mac_ctl.last) : (mac_ctl.k == $past(mac_ctl.k) + 3'd1)))
		else $error("k stepped out of order or wrapped without a last step");

endmodule

/* hdl/idct_top.sv */
`timescale 1ns/1ps

module idct_top (
	input logic Clock,
	input logic Resetn,
	input logic start,
	input idct_pkg::coef_wr_t coef_wr,
	output idct_pkg::pixel_t pixel,
	output logic busy,
	output logic done
);

	logic coef_wr_en;
	logic [idct_pkg::ADDR_WIDTH-1:0] coef_wr_addr;
	idct_pkg::ram_rd_t coef_rd;
	idct_pkg::ram_rd_t t_rd;
	idct_pkg::mac_ctl_t mac_ctl;
	logic signed [idct_pkg::COEF_WIDTH-1:0] coef_data;
	logic signed [idct_pkg::T_WIDTH-1:0] t_data;
	logic t_wr_en;
	logic [idct_pkg::ADDR_WIDTH-1:0] t_wr_addr;
	logic signed [idct_pkg::T_WIDTH-1:0] t_wr_data;

	idct_sequencer i_sequencer (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.coef_wr(coef_wr),
		.coef_wr_en(coef_wr_en),
		.coef_wr_addr(coef_wr_addr),
		.coef_rd(coef_rd),
		.t_rd(t_rd),
		.mac_ctl(mac_ctl),
		.busy(busy),
		.done(done)
	);

	// Coefficient store
	idct_dual_port_ram #(.WIDTH(idct_pkg::COEF_WIDTH)) i_coef_ram (
		.Clock(Clock),
		.wr_en(coef_wr_en),
		.wr_addr(coef_wr_addr),
		.wr_data(coef_wr.data),
		.rd(coef_rd),
		.rd_data(coef_data)
	);

	// Row pass results
	idct_dual_port_ram #(.WIDTH(idct_pkg::T_WIDTH)) i_t_ram (
		.Clock(Clock),
		.wr_en(t_wr_en),
		.wr_addr(t_wr_addr),
		.wr_data(t_wr_data),
		.rd(t_rd),
		.rd_data(t_data)
	);

	idct_mac i_mac (
		.Clock(Clock),
		.Resetn(Resetn),
		.mac_ctl(mac_ctl),
		.coef_data(coef_data),
		.t_data(t_data),
		.t_wr_en(t_wr_en),
		.t_wr_addr(t_wr_addr),
		.t_wr_data(t_wr_data),
		.pixel(pixel)
	);

endmodule

/* idct.f */
hdl/idct_pkg.sv
hdl/idct_dual_port_ram.sv
hdl/idct_sequencer.sv
hdl/idct_mac.sv
hdl/idct_top.sv
verif/idct_tb.sv

/* verif/idct_tb.sv */
`timescale 1ns/1ps

module idct_tb;

	typedef logic signed [15:0] coef_blk_t [64];
	typedef logic [7:0] pix_blk_t [64];

	logic Clock;
	logic Resetn;
	logic start;
	idct_pkg::coef_wr_t coef_wr;
	idct_pkg::pixel_t pixel;
	logic busy;
	logic done;

	integer seed = 32'hec10;
	int errors = 0;
	int checks = 0;
	int done_count = 0;
	int pix_at_done = 0;
	idct_pkg::pixel_t pix_q [$];
	coef_blk_t coefs;
	pix_blk_t expected;

	idct_top i_idct_top (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.coef_wr(coef_wr),
		.pixel(pixel),
		.busy(busy),
		.done(done)
	);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	// Row pass, shift by 8, column pass, shift by 16 and clip
	function automatic pix_blk_t ref_idct(input coef_blk_t c);
		pix_blk_t p;
		logic signed [23:0] t [64];
		int acc;
		int i;
		int j;
		int k;
		for (i = 0; i < 8; i++) begin
			for (j = 0; j < 8; j++) begin
				acc = 0;
				for (k = 0; k < 8; k++) begin
					acc += int'(c[i*8+k]) * int'(idct_pkg::DCT_MATRIX[k][j]);
				end
				t[i*8+j] = acc >>> 8;
			end
		end
		for (i = 0; i < 8; i++) begin
			for (j = 0; j < 8; j++) begin
				acc = 0;
				for (k = 0; k < 8; k++) begin
					acc += int'(idct_pkg::DCT_MATRIX[k][i]) * int'(t[k*8+j]);
				end
				if (acc < 0) begin
					p[i*8+j] = 8'd0;
				end else if (acc >= 32'h0100_0000) begin
					p[i*8+j] = 8'd255;
				end else begin
					p[i*8+j] = acc >>> 16;
				end
			end
		end
		return p;
	endfunction

	// Pixel and done monitor, done first so a same-cycle pixel counts as late
	always @(posedge Clock) begin
		if (Resetn) begin
			if (done) begin
				done_count++;
				pix_at_done = pix_q.size();
				checks++;
				assert (!busy) else begin
					errors++;
					$display("Mismatch at %0t: busy got %b expected %b with done",
						$time, busy, 1'b0);
				end
			end
			if (pixel.valid) begin
				pix_q.push_back(pixel);
				checks++;
				assert (busy) else begin
					errors++;
					$display("Mismatch at %0t: busy got %b expected %b with a pixel",
						$time, busy, 1'b1);
				end
			end
		end
	end

	task automatic write_block(input coef_blk_t c);
		int a;
		for (a = 0; a < 64; a++) begin
			@(posedge Clock);
			#2;
			coef_wr.we = 1'b1;
			coef_wr.addr = a[5:0];
			coef_wr.data = c[a];
		end
		@(posedge Clock);
		#2;
		coef_wr = '0;
	endtask

	task automatic pulse_start;
		@(posedge Clock);
		#2;
		start = 1'b1;
		@(posedge Clock);
		#2;
		start = 1'b0;
	endtask

	// Garbage writes while the engine runs, then a stray start mid column pass
	task automatic disturb_while_busy;
		int a;
		int cycles;
		for (a = 0; a < 64; a++) begin
			@(posedge Clock);
			#2;
			coef_wr.we = 1'b1;
			coef_wr.addr = a[5:0];
			coef_wr.data = 16'sh7abc ^ a[15:0];
		end
		@(posedge Clock);
		#2;
		coef_wr = '0;
		cycles = 0;
		while ((pix_q.size() == 0) && (cycles < 2000)) begin
			@(posedge Clock);
			#2;
			cycles++;
		end
		if (pix_q.size() == 0) begin
			errors++;
			$display("Timed out after 2000 cycles waiting for the first pixel at %0t", $time);
		end
		start = 1'b1;
		@(posedge Clock);
		#2;
		start = 1'b0;
	endtask

	task automatic compare_block(input pix_blk_t exp, input int done_before);
		int i;
		checks++;
		assert (done_count == done_before + 1) else begin
			errors++;
			$display("Expected one done pulse at %0t but saw %0d", $time, done_count - done_before);
		end
		checks++;
		assert (pix_q.size() == 64) else begin
			errors++;
			$display("Expected 64 pixel strobes at %0t but saw %0d", $time, pix_q.size());
		end
		checks++;
		assert (pix_at_done == 64) else begin
			errors++;
			$display("Done arrived at %0t after only %0d pixels", $time, pix_at_done);
		end
		for (i = 0; i < pix_q.size() && i < 64; i++) begin
			checks++;
			assert (pix_q[i].index == i[5:0]) else begin
				errors++;
				$display("Mismatch at %0t: pixel.index[%0d] got %0d expected %0d",
					$time, i, pix_q[i].index, i);
			end
			checks++;
			assert (pix_q[i].value == exp[i]) else begin
				errors++;
				$display("Mismatch at %0t: pixel.value[%0d] got %0d expected %0d",
					$time, i, pix_q[i].value, exp[i]);
			end
		end
	endtask

	task automatic run_block(input pix_blk_t exp, input bit disturb);
		int cycles;
		int done_before;
		pix_q.delete();
		done_before = done_count;
		pulse_start();
		checks++;
		assert (busy) else begin
			errors++;
			$display("Mismatch at %0t: busy got %b expected %b after start",
				$time, busy, 1'b1);
		end
		if (disturb) begin
			disturb_while_busy();
		end
		cycles = 0;
		while ((done_count == done_before) && (cycles < 2000)) begin
			@(posedge Clock);
			#1;
			cycles++;
		end
		if (done_count == done_before) begin
			errors++;
			$display("Timed out after 2000 cycles waiting for done at %0t", $time);
		end else begin
			repeat (4) @(posedge Clock); // Catch stray pixels or a second done
			#1;
			compare_block(exp, done_before);
		end
	endtask

	initial begin
		int n;
		int b;
		Resetn = 1'b0;
		start = 1'b0;
		coef_wr = '0;
		repeat (4) @(posedge Clock);
		#2;
		Resetn = 1'b1;

		// Quiet after reset
		for (n = 0; n < 10; n++) begin
			@(posedge Clock);
			#1;
			checks++;
			assert (!busy && !done && !pixel.valid) else begin
				errors++;
				$display("Outputs active at %0t with no start: busy %b done %b valid %b",
					$time, busy, done, pixel.valid);
			end
		end

		// DC only
		for (n = 0; n < 64; n++) begin
			coefs[n] = 16'sd0;
		end
		coefs[0] = 16'sd256;
		write_block(coefs);
		run_block(ref_idct(coefs), 1'b0);

		for (b = 0; b < 5; b++) begin
			for (n = 0; n < 64; n++) begin
				coefs[n] = $random(seed) % 513;
			end
			write_block(coefs);
			run_block(ref_idct(coefs), 1'b0);
		end

		// Clipping high and low
		for (n = 0; n < 64; n++) begin
			coefs[n] = 16'sd0;
			expected[n] = 8'd255;
		end
		coefs[0] = 16'sd20000;
		write_block(coefs);
		run_block(expected, 1'b0);
		for (n = 0; n < 64; n++) begin
			expected[n] = 8'd0;
		end
		coefs[0] = -16'sd20000;
		write_block(coefs);
		run_block(expected, 1'b0);

		// Writes and start while busy are dropped, then rerun without reload
		for (n = 0; n < 64; n++) begin
			coefs[n] = $random(seed) % 513;
		end
		write_block(coefs);
		expected = ref_idct(coefs);
		run_block(expected, 1'b1);
		run_block(expected, 1'b0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
